// File: lsu.f
+incdir+common
common/lsu_pkg.sv
design/pipe_slot.sv
design/exe_stage.sv
design/mem_stage.sv
design/wb_stage.sv
design/data_sram.sv
design/lsu_top.sv
verification/lsu_tb.sv

// File: verification/lsu_tb.sv
`include "lsu_defines.svh"

module lsu_tb
    import lsu_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 10;
    localparam logic [31:0] PC_BASE = 32'h1c00_0000;

    typedef struct packed {
        mem_op_e     op;
        logic [31:0] base;
        logic [31:0] offset;
        logic [31:0] sdata;
        logic        rnd;
        logic        gr_we;
        logic [4:0]  dest;
        logic [3:0]  gap;
    } stim_t;

    // one expected writeback or exception
    typedef struct packed {
        logic        exc;
        logic [4:0]  dest;
        logic [31:0] data;
        logic [31:0] pc;
        logic [31:0] cycle;
    } expect_t;

    logic                   clk = 1'b0;
    logic                   reset;
    logic                   in_valid;
    mem_op_e                in_op;
    logic [`LSU_XLEN-1:0]   in_base;
    logic [`LSU_XLEN-1:0]   in_offset;
    logic [`LSU_XLEN-1:0]   in_store_data;
    logic                   in_gr_we;
    logic [`LSU_REG_AW-1:0] in_dest;
    logic [`LSU_XLEN-1:0]   in_pc;
    logic                   rf_we;
    logic [`LSU_REG_AW-1:0] rf_waddr;
    logic [`LSU_XLEN-1:0]   rf_wdata;
    logic [`LSU_XLEN-1:0]   wb_pc;
    logic                   exc_valid;
    logic [`LSU_XLEN-1:0]   exc_pc;

    stim_t       stim_q[$];
    expect_t     exp_q[$];
    logic [31:0] ref_mem [1 << `LSU_SRAM_AW];
    logic [31:0] lfsr_state = 32'h0d4d_f676;
    int          cycle = 0;
    int          kill_until = 0;
    logic        table_built = 1'b0;

    lsu_top u_lsu_top (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_op(in_op), .in_base(in_base),
        .in_offset(in_offset), .in_store_data(in_store_data), .in_gr_we(in_gr_we),
        .in_dest(in_dest), .in_pc(in_pc), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .wb_pc(wb_pc), .exc_valid(exc_valid), .exc_pc(exc_pc));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Result: FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    // one lfsr step per bit
    task automatic random_word(output logic [31:0] v);
        v = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic add_entry(input mem_op_e op, input logic [31:0] base,
                             input logic [31:0] offset, input logic [31:0] sdata,
                             input logic rnd, input logic gr_we, input logic [4:0] dest,
                             input logic [3:0] gap);
        stim_q.push_back('{op, base, offset, sdata, rnd, gr_we, dest, gap});
    endtask

    // reference model, entries handled in issue order
    task automatic model_entry(input stim_t s, input logic [31:0] sdata,
                               input logic [31:0] pc, input int edge_no);
        logic [31:0]             addr;
        logic [31:0]             word;
        logic [31:0]             result;
        logic [7:0]              b;
        logic [15:0]             h;
        logic                    misal;
        logic [`LSU_SRAM_AW-1:0] widx;
        expect_t                 e;
        addr = s.base + s.offset;
        widx = addr[`LSU_SRAM_AW+1:2];
        case (s.op)
            op_ld_h, op_ld_hu, op_st_h: misal = addr[0];
            op_ld_w, op_st_w:           misal = (addr[1:0] != 2'b00);
            default:                    misal = 1'b0;
        endcase
        e = '{exc: 1'b0, dest: s.dest, data: 32'h0, pc: pc, cycle: edge_no + 2};
        // discarded by an older exception
        if (edge_no > kill_until) begin
            if (misal) begin
                e.exc = 1'b1;
                kill_until = edge_no + 3;
                exp_q.push_back(e);
            end else begin
                result = addr;
                word = ref_mem[widx];
                b = word[8*addr[1:0] +: 8];
                h = word[16*addr[1] +: 16];
                case (s.op)
                    op_ld_b:  result = {{24{b[7]}}, b};
                    op_ld_bu: result = {24'h0, b};
                    op_ld_h:  result = {{16{h[15]}}, h};
                    op_ld_hu: result = {16'h0, h};
                    op_ld_w:  result = word;
                    op_st_b:  ref_mem[widx][8*addr[1:0] +: 8] = sdata[7:0];
                    op_st_h:  ref_mem[widx][16*addr[1] +: 16] = sdata[15:0];
                    op_st_w:  ref_mem[widx] = sdata;
                    default:  result = addr;
                endcase
                if (s.gr_we) begin
                    e.data = result;
                    exp_q.push_back(e);
                end
            end
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        logic    fired;
        fired = rf_we || exc_valid;
        check_value(rf_we && exc_valid, 1'b0, "rf_we and exc_valid high together");
        if (exp_q.size() == 0) begin
            check_value(fired, 1'b0, "writeback output with nothing expected");
        end else begin
            e = exp_q[0];
            if (fired || e.cycle == cycle) begin
                check_value(fired, 1'b1, "writeback missing at expected cycle");
                check_value(cycle, e.cycle, "writeback cycle");
                check_value(exc_valid, e.exc, "exception flag");
                if (e.exc) begin
                    check_value(exc_pc, e.pc, "exception pc");
                end else begin
                    check_value(rf_waddr, e.dest, "rf_waddr");
                    check_value(rf_wdata, e.data, "rf_wdata");
                    check_value(wb_pc, e.pc, "wb_pc");
                end
                void'(exp_q.pop_front());
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            check_outputs();
        end
    end

    initial begin
        int max_gap;
        int limit;
        wait (table_built);
        max_gap = 0;
        foreach (stim_q[i]) begin
            if (stim_q[i].gap > max_gap) begin
                max_gap = stim_q[i].gap;
            end
        end
        limit = RESET_CYCLES + stim_q.size() * (max_gap + 1) + 30;
        repeat (limit) @(posedge clk);
        $display("watchdog expired: the writeback stream never finished");
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        logic [31:0] sdata;
        reset = 1'b1;
        in_valid = 1'b0;
        in_op = op_alu;
        in_base = '0;
        in_offset = '0;
        in_store_data = '0;
        in_gr_we = 1'b0;
        in_dest = '0;
        in_pc = '0;

        // word stores then word loads
        add_entry(op_st_w,  32'h100, 32'h0, 32'h1122_3344, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_st_w,  32'h100, 32'h4, 32'h0, 1'b1, 1'b0, 5'd0, 4'd0);
        add_entry(op_st_w,  32'h100, 32'h8, 32'h8765_43a9, 1'b0, 1'b0, 5'd0, 4'd1);
        add_entry(op_ld_w,  32'h100, 32'h0, 32'h0, 1'b0, 1'b1, 5'd1, 4'd0);
        add_entry(op_ld_w,  32'h104, 32'h0, 32'h0, 1'b0, 1'b1, 5'd2, 4'd2);
        add_entry(op_ld_w,  32'h10c, 32'hffff_fffc, 32'h0, 1'b0, 1'b1, 5'd3, 4'd0);
        // sub-word loads at every legal offset
        add_entry(op_ld_b,  32'h108, 32'h0, 32'h0, 1'b0, 1'b1, 5'd4, 4'd0);
        add_entry(op_ld_b,  32'h108, 32'h1, 32'h0, 1'b0, 1'b1, 5'd5, 4'd0);
        add_entry(op_ld_bu, 32'h108, 32'h2, 32'h0, 1'b0, 1'b1, 5'd6, 4'd0);
        add_entry(op_ld_bu, 32'h108, 32'h3, 32'h0, 1'b0, 1'b1, 5'd7, 4'd0);
        add_entry(op_ld_b,  32'h108, 32'h3, 32'h0, 1'b0, 1'b1, 5'd8, 4'd0);
        add_entry(op_ld_h,  32'h108, 32'h0, 32'h0, 1'b0, 1'b1, 5'd9, 4'd0);
        add_entry(op_ld_h,  32'h108, 32'h2, 32'h0, 1'b0, 1'b1, 5'd10, 4'd0);
        add_entry(op_ld_hu, 32'h108, 32'h0, 32'h0, 1'b0, 1'b1, 5'd11, 4'd0);
        add_entry(op_ld_hu, 32'h108, 32'h2, 32'h0, 1'b0, 1'b1, 5'd12, 4'd1);
        // sub-word stores merge into the word
        add_entry(op_st_w,  32'h10c, 32'h0, 32'hdead_beef, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_st_b,  32'h10c, 32'h1, 32'h0000_0055, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_w,  32'h10c, 32'h0, 32'h0, 1'b0, 1'b1, 5'd13, 4'd0);
        add_entry(op_st_h,  32'h10c, 32'h2, 32'h0000_a5c3, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_w,  32'h10c, 32'h0, 32'h0, 1'b0, 1'b1, 5'd14, 4'd0);
        add_entry(op_st_b,  32'h10c, 32'h0, 32'h0, 1'b1, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_bu, 32'h10c, 32'h0, 32'h0, 1'b0, 1'b1, 5'd15, 4'd1);
        // plain ops and gr_we cleared
        add_entry(op_alu,   32'h1234_0000, 32'h5678, 32'h0, 1'b0, 1'b1, 5'd16, 4'd0);
        add_entry(op_alu,   32'h1234_0000, 32'h9, 32'h0, 1'b0, 1'b0, 5'd17, 4'd0);
        add_entry(op_ld_w,  32'h100, 32'h0, 32'h0, 1'b0, 1'b0, 5'd18, 4'd0);
        add_entry(op_alu,   32'hffff_fff0, 32'h20, 32'h0, 1'b0, 1'b1, 5'd19, 4'd2);
        // misaligned halfword, three younger entries flushed
        add_entry(op_st_w,  32'h110, 32'h0, 32'h0bad_f00d, 1'b0, 1'b0, 5'd0, 4'd1);
        add_entry(op_ld_h,  32'h110, 32'h1, 32'h0, 1'b0, 1'b1, 5'd20, 4'd0);
        add_entry(op_st_w,  32'h110, 32'h0, 32'hffff_ffff, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_w,  32'h100, 32'h0, 32'h0, 1'b0, 1'b1, 5'd21, 4'd0);
        add_entry(op_st_b,  32'h110, 32'h0, 32'h0000_0077, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_w,  32'h110, 32'h0, 32'h0, 1'b0, 1'b1, 5'd22, 4'd2);
        // misaligned word store
        add_entry(op_st_w,  32'h110, 32'h2, 32'h0000_0001, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_alu,   32'h40, 32'h4, 32'h0, 1'b0, 1'b1, 5'd23, 4'd0);
        add_entry(op_st_h,  32'h110, 32'h0, 32'h0000_2222, 1'b0, 1'b0, 5'd0, 4'd0);
        add_entry(op_ld_hu, 32'h108, 32'h0, 32'h0, 1'b0, 1'b1, 5'd24, 4'd0);
        add_entry(op_ld_w,  32'h110, 32'h0, 32'h0, 1'b0, 1'b1, 5'd25, 4'd0);
        // misaligned word load, then back to back traffic
        add_entry(op_ld_w,  32'h100, 32'h3, 32'h0, 1'b0, 1'b1, 5'd26, 4'd3);
        add_entry(op_ld_w,  32'h104, 32'h0, 32'h0, 1'b0, 1'b1, 5'd27, 4'd0);
        add_entry(op_ld_h,  32'h10c, 32'h2, 32'h0, 1'b0, 1'b1, 5'd28, 4'd0);
        add_entry(op_alu,   32'h7fff_ffff, 32'h1, 32'h0, 1'b0, 1'b1, 5'd29, 4'd0);
        table_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        foreach (stim_q[i]) begin
            @(negedge clk);
            sdata = stim_q[i].sdata;
            if (stim_q[i].rnd) begin
                random_word(sdata);
            end
            in_valid = 1'b1;
            in_op = stim_q[i].op;
            in_base = stim_q[i].base;
            in_offset = stim_q[i].offset;
            in_store_data = sdata;
            in_gr_we = stim_q[i].gr_we;
            in_dest = stim_q[i].dest;
            in_pc = PC_BASE + 4 * i;
            model_entry(stim_q[i], sdata, PC_BASE + 4 * i, cycle + 1);
            repeat (stim_q[i].gap) begin
                @(negedge clk);
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        // catch any stray output after the last expected one
        repeat (5) @(negedge clk);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: design/lsu_top.sv
`include "lsu_defines.svh"

module lsu_top
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  mem_op_e                in_op,
    input  logic [`LSU_XLEN-1:0]   in_base,
    input  logic [`LSU_XLEN-1:0]   in_offset,
    input  logic [`LSU_XLEN-1:0]   in_store_data,
    input  logic                   in_gr_we,
    input  logic [`LSU_REG_AW-1:0] in_dest,
    input  logic [`LSU_XLEN-1:0]   in_pc,
    output logic                   rf_we,
    output logic [`LSU_REG_AW-1:0] rf_waddr,
    output logic [`LSU_XLEN-1:0]   rf_wdata,
    output logic [`LSU_XLEN-1:0]   wb_pc,
    output logic                   exc_valid,
    output logic [`LSU_XLEN-1:0]   exc_pc
);

    ex_payload_t  ex_in;
    ex_payload_t  ex_q;
    mem_payload_t mem_d;
    mem_payload_t mem_q;
    wb_payload_t  wb_d;
    wb_payload_t  wb_q;
    logic         ex_valid, mem_valid_d, mem_valid_q, wb_valid_d, wb_valid_q;
    logic         ms_exc, wb_ex;
    logic [`LSU_SRAM_AW-1:0] sram_addr;
    logic [3:0]              sram_we;
    logic [`LSU_XLEN-1:0]    sram_wdata, sram_rdata;

    assign ex_in = '{op: in_op, base: in_base, offset: in_offset, store_data: in_store_data,
                     gr_we: in_gr_we, dest: in_dest, pc: in_pc};

    // faulting op sitting in the memory slot
    assign ms_exc = mem_valid_q && mem_q.misaligned;

    pipe_slot #(.payload_t(ex_payload_t)) u_ex_slot (
        .clk(clk), .reset(reset), .flush(wb_ex), .in_valid(in_valid),
        .in_payload(ex_in), .valid(ex_valid), .payload(ex_q));

    exe_stage u_exe_stage (
        .ex_valid(ex_valid), .ex_payload(ex_q), .ms_exc(ms_exc), .wb_ex(wb_ex),
        .sram_addr(sram_addr), .sram_we(sram_we), .sram_wdata(sram_wdata),
        .mem_valid(mem_valid_d), .mem_payload(mem_d));

    data_sram u_data_sram (
        .clk(clk), .addr(sram_addr), .we(sram_we), .wdata(sram_wdata), .rdata(sram_rdata));

    pipe_slot #(.payload_t(mem_payload_t)) u_mem_slot (
        .clk(clk), .reset(reset), .flush(wb_ex), .in_valid(mem_valid_d),
        .in_payload(mem_d), .valid(mem_valid_q), .payload(mem_q));

    mem_stage u_mem_stage (
        .mem_valid(mem_valid_q), .mem_payload(mem_q), .sram_rdata(sram_rdata),
        .wb_valid(wb_valid_d), .wb_payload(wb_d));

    // also flushed, or the op behind the fault would reach writeback
    pipe_slot #(.payload_t(wb_payload_t)) u_wb_slot (
        .clk(clk), .reset(reset), .flush(wb_ex), .in_valid(wb_valid_d),
        .in_payload(wb_d), .valid(wb_valid_q), .payload(wb_q));

    wb_stage u_wb_stage (
        .wb_valid(wb_valid_q), .wb_payload(wb_q), .rf_we(rf_we), .rf_waddr(rf_waddr),
        .rf_wdata(rf_wdata), .wb_pc(wb_pc), .exc_valid(exc_valid), .exc_pc(exc_pc),
        .wb_ex(wb_ex));

endmodule

// File: design/data_sram.sv
`include "lsu_defines.svh"

module data_sram (
    input  logic                    clk,
    input  logic [`LSU_SRAM_AW-1:0] addr,
    input  logic [3:0]              we,
    input  logic [`LSU_XLEN-1:0]    wdata,
    output logic [`LSU_XLEN-1:0]    rdata
);

    localparam int DEPTH = 1 << `LSU_SRAM_AW;

    logic [`LSU_XLEN-1:0] mem [DEPTH];

    // per byte lane write
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (we[b]) begin
                mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

// File: design/wb_stage.sv
`include "lsu_defines.svh"

module wb_stage
    import lsu_pkg::*;
(
    input  logic                   wb_valid,
    input  wb_payload_t            wb_payload,
    output logic                   rf_we,
    output logic [`LSU_REG_AW-1:0] rf_waddr,
    output logic [`LSU_XLEN-1:0]   rf_wdata,
    output logic [`LSU_XLEN-1:0]   wb_pc,
    output logic                   exc_valid,
    output logic [`LSU_XLEN-1:0]   exc_pc,
    output logic                   wb_ex
);

    // register write only for a clean entry
    assign rf_we    = wb_valid && wb_payload.gr_we && !wb_payload.misaligned;
    assign rf_waddr = wb_payload.dest;
    assign rf_wdata = wb_payload.result;
    assign wb_pc    = wb_payload.pc;

    // misaligned entry raises the exception
    assign exc_valid = wb_valid && wb_payload.misaligned;
    assign exc_pc    = wb_payload.pc;

    // flush of everything younger
    assign wb_ex = exc_valid;

endmodule

// File: design/mem_stage.sv
`include "lsu_defines.svh"

module mem_stage
    import lsu_pkg::*;
(
    input  logic                 mem_valid,
    input  mem_payload_t         mem_payload,
    input  logic [`LSU_XLEN-1:0] sram_rdata,
    output logic                 wb_valid,
    output wb_payload_t          wb_payload
);

    logic [1:0]           sel;
    logic [7:0]           ld_byte;
    logic [15:0]          ld_half;
    logic                 is_load;
    logic [`LSU_XLEN-1:0] mem_result;

    assign sel = mem_payload.addr[1:0];

    // pick the addressed byte
    always_comb begin
        case (sel)
            2'b00:   ld_byte = sram_rdata[7:0];
            2'b01:   ld_byte = sram_rdata[15:8];
            2'b10:   ld_byte = sram_rdata[23:16];
            default: ld_byte = sram_rdata[31:24];
        endcase
    end

    // halfword lane, bit 0 is known clear for legal accesses
    assign ld_half = sel[1] ? sram_rdata[31:16] : sram_rdata[15:0];

    always_comb begin
        case (mem_payload.op)
            op_ld_b:  mem_result = {{24{ld_byte[7]}}, ld_byte};
            op_ld_bu: mem_result = {24'b0, ld_byte};
            op_ld_h:  mem_result = {{16{ld_half[15]}}, ld_half};
            op_ld_hu: mem_result = {16'b0, ld_half};
            default:  mem_result = sram_rdata;
        endcase
    end

    assign is_load = (mem_payload.op == op_ld_b) || (mem_payload.op == op_ld_bu) ||
                     (mem_payload.op == op_ld_h) || (mem_payload.op == op_ld_hu) ||
                     (mem_payload.op == op_ld_w);

    assign wb_valid = mem_valid;

    // stores and plain ops hand the address on as result
    always_comb begin
        wb_payload.result     = is_load ? mem_result : mem_payload.addr;
        wb_payload.misaligned = mem_payload.misaligned;
        wb_payload.gr_we      = mem_payload.gr_we;
        wb_payload.dest       = mem_payload.dest;
        wb_payload.pc         = mem_payload.pc;
    end

endmodule

// File: design/exe_stage.sv
`include "lsu_defines.svh"

module exe_stage
    import lsu_pkg::*;
(
    input  logic                    ex_valid,
    input  ex_payload_t             ex_payload,
    input  logic                    ms_exc,
    input  logic                    wb_ex,
    output logic [`LSU_SRAM_AW-1:0] sram_addr,
    output logic [3:0]              sram_we,
    output logic [`LSU_XLEN-1:0]    sram_wdata,
    output logic                    mem_valid,
    output mem_payload_t            mem_payload
);

    logic [`LSU_XLEN-1:0] addr;
    logic                 is_half;
    logic                 is_word;
    logic                 is_store;
    logic                 misaligned;
    logic [3:0]           store_be;
    logic                 store_ok;

    assign addr = ex_payload.base + ex_payload.offset;

    assign is_half  = (ex_payload.op == op_ld_h) || (ex_payload.op == op_ld_hu) ||
                      (ex_payload.op == op_st_h);
    assign is_word  = (ex_payload.op == op_ld_w) || (ex_payload.op == op_st_w);
    assign is_store = (ex_payload.op == op_st_b) || (ex_payload.op == op_st_h) ||
                      (ex_payload.op == op_st_w);

    assign misaligned = (is_half && addr[0]) || (is_word && (addr[1:0] != 2'b00));

    // lane enables and replicated write data
    always_comb begin
        store_be   = 4'b0000;
        sram_wdata = ex_payload.store_data;
        case (ex_payload.op)
            op_st_b: begin
                store_be   = 4'b0001 << addr[1:0];
                sram_wdata = {4{ex_payload.store_data[7:0]}};
            end
            op_st_h: begin
                store_be   = addr[1] ? 4'b1100 : 4'b0011;
                sram_wdata = {2{ex_payload.store_data[15:0]}};
            end
            op_st_w: begin
                store_be = 4'b1111;
            end
            default: begin
                store_be = 4'b0000;
            end
        endcase
    end

    // no write once an older op has faulted
    assign store_ok  = ex_valid && is_store && !misaligned && !ms_exc && !wb_ex;
    assign sram_we   = store_ok ? store_be : 4'b0000;
    assign sram_addr = addr[`LSU_SRAM_AW+1:2];

    assign mem_valid = ex_valid;

    always_comb begin
        mem_payload.op         = ex_payload.op;
        mem_payload.addr       = addr;
        mem_payload.misaligned = misaligned;
        mem_payload.gr_we      = ex_payload.gr_we;
        mem_payload.dest       = ex_payload.dest;
        mem_payload.pc         = ex_payload.pc;
    end

endmodule

// File: design/pipe_slot.sv
module pipe_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     valid,
    output payload_t payload
);

    // stages always accept, so valid just follows the upstream valid
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (flush) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    // payload only moves with a real entry
    always_ff @(posedge clk) begin
        if (in_valid) begin
            payload <= in_payload;
        end
    end

endmodule

// File: common/lsu_pkg.sv
`include "lsu_defines.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        op_alu,
        op_ld_b,
        op_ld_bu,
        op_ld_h,
        op_ld_hu,
        op_ld_w,
        op_st_b,
        op_st_h,
        op_st_w
    } mem_op_e;

    // execute slot content, straight from the issue side
    typedef struct packed {
        mem_op_e                 op;
        logic [`LSU_XLEN-1:0]    base;
        logic [`LSU_XLEN-1:0]    offset;
        logic [`LSU_XLEN-1:0]    store_data;
        logic                    gr_we;
        logic [`LSU_REG_AW-1:0]  dest;
        logic [`LSU_XLEN-1:0]    pc;
    } ex_payload_t;

    // memory slot content
    typedef struct packed {
        mem_op_e                 op;
        logic [`LSU_XLEN-1:0]    addr;
        logic                    misaligned;
        logic                    gr_we;
        logic [`LSU_REG_AW-1:0]  dest;
        logic [`LSU_XLEN-1:0]    pc;
    } mem_payload_t;

    // writeback slot content
    typedef struct packed {
        logic [`LSU_XLEN-1:0]    result;
        logic                    misaligned;
        logic                    gr_we;
        logic [`LSU_REG_AW-1:0]  dest;
        logic [`LSU_XLEN-1:0]    pc;
    } wb_payload_t;

endpackage

// File: common/lsu_defines.svh
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data path and address width
`define LSU_XLEN 32

// destination register index width
`define LSU_REG_AW 5

// data sram word address width, 1024 words
`define LSU_SRAM_AW 10

`endif
